/* verilog.f */
+incdir+rtl
rtl/fe_pkg.sv
rtl/instr_mem.sv
rtl/mem_arbiter.sv
rtl/host_port.sv
rtl/fetch_unit.sv
rtl/fetch_chk.sv
rtl/fe_top.sv
tb/tb_clock.sv
tb/fe_tb.sv

/* Bender.yml */
package:
  name: fe_front

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/fe_pkg.sv
      - rtl/instr_mem.sv
      - rtl/mem_arbiter.sv
      - rtl/host_port.sv
      - rtl/fetch_unit.sv
      - rtl/fetch_chk.sv
      - rtl/fe_top.sv

  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/tb_clock.sv
      - tb/fe_tb.sv

/* tb/fe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fe_settings.svh"

module fe_tb
    import fe_pkg::*;
;

    localparam int RESET_CYCLES = 10;
    localparam int N_WORDS      = `FE_MEM_WORDS;
    localparam int N_PRE_READS  = 40;
    localparam int N_RUN        = 3000;
    localparam int HOST_WAIT    = 40;
    localparam int MARGIN       = 500;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + (N_WORDS + N_PRE_READS) * 4 + N_RUN + MARGIN;

    logic   clk;
    logic   reset;
    logic   decode_ready;
    logic   br_mispred;
    paddr_t br_target;
    logic   nuke;
    paddr_t nuke_target;
    logic   instr_valid;
    paddr_t instr_pc;
    instr_t instr;
    logic   host_req;
    logic   host_we;
    paddr_t host_addr;
    word_t  host_wdata;
    logic   host_done;
    word_t  host_rdata;
    logic   pc_error;

    word_t  model_mem [0:N_WORDS-1];
    paddr_t exp_pc;
    logic   prev_stall;
    paddr_t prev_pc;
    instr_t prev_instr;
    logic   run_over;
    int     errors;
    int     n_xfer;
    int     n_reads;
    int     n_redirects;
    int     n_both;
    int     seed_draw;

    tb_clock #(.PERIOD_NS(20)) u_tb_clock (.clk(clk));

    fe_top u_fe_top (
        .clk          (clk),
        .reset        (reset),
        .decode_ready (decode_ready),
        .br_mispred   (br_mispred),
        .br_target    (br_target),
        .nuke         (nuke),
        .nuke_target  (nuke_target),
        .instr_valid  (instr_valid),
        .instr_pc     (instr_pc),
        .instr        (instr),
        .host_req     (host_req),
        .host_we      (host_we),
        .host_addr    (host_addr),
        .host_wdata   (host_wdata),
        .host_done    (host_done),
        .host_rdata   (host_rdata),
        .pc_error     (pc_error)
    );

    function automatic paddr_t random_target();
        paddr_t t;
        t = paddr_t'($urandom_range(N_WORDS - 1)) << 2;
        return t;
    endfunction

    // one strobed host access, then wait for its done strobe.
    task automatic host_access(input logic we, input paddr_t a, input word_t wd,
                               output word_t rd, output logic ok);
        int waited;
        ok = 1'b0;
        rd = '0;
        waited = 0;
        @(posedge clk);
        #1;
        host_req   = 1'b1;
        host_we    = we;
        host_addr  = a;
        host_wdata = wd;
        @(posedge clk);
        #1;
        host_req = 1'b0;
        while (!ok && waited < HOST_WAIT) begin
            @(negedge clk);
            if (host_done === 1'b1) begin
                ok = 1'b1;
                rd = host_rdata;
            end
            waited++;
        end
    endtask

    task automatic load_word(input int idx, input word_t data);
        word_t rd;
        logic  ok;
        model_mem[idx] = data;
        host_access(1'b1, paddr_t'(idx) << 2, data, rd, ok);
        assert (ok) else begin
            errors++;
            $display("host write to word %0d never completed", idx);
        end
    endtask

    task automatic read_and_compare(input int idx);
        word_t rd;
        logic  ok;
        host_access(1'b0, paddr_t'(idx) << 2, '0, rd, ok);
        n_reads++;
        assert (ok) else begin
            errors++;
            $display("host read of word %0d never completed", idx);
        end
        if (ok) begin
            assert (rd === model_mem[idx]) else begin
                errors++;
                $display("mismatch at %0t: host read word %0d got %h expected %h",
                         $time, idx, rd, model_mem[idx]);
            end
        end
    endtask

    // decode side model, sampled half a cycle after the inputs settle.
    always @(negedge clk) begin
        logic redir;
        logic xfer;
        redir = (nuke === 1'b1) || (br_mispred === 1'b1);
        xfer  = (instr_valid === 1'b1) && (decode_ready === 1'b1);
        if (reset !== 1'b0) begin
            prev_stall = 1'b0;
        end else begin
            assert (pc_error === 1'b0) else begin
                errors++;
                $display("mismatch at %0t: pc_error raised at pc %h", $time, instr_pc);
            end
            if (prev_stall && !redir) begin
                assert (instr_valid === 1'b1 && instr_pc === prev_pc && instr === prev_instr)
                else begin
                    errors++;
                    $display("mismatch at %0t: stalled output changed to pc %h instr %h",
                             $time, instr_pc, instr);
                end
            end
            if (xfer) begin
                n_xfer++;
                assert (instr_pc === exp_pc) else begin
                    errors++;
                    $display("mismatch at %0t: instr_pc %h expected %h",
                             $time, instr_pc, exp_pc);
                end
                assert (instr === model_mem[instr_pc[`FE_ADDR_W-1:2]]) else begin
                    errors++;
                    $display("mismatch at %0t: instr %h at pc %h expected %h", $time,
                             instr, instr_pc, model_mem[instr_pc[`FE_ADDR_W-1:2]]);
                end
                exp_pc = exp_pc + paddr_t'(4);
            end
            if (redir) begin
                n_redirects++;
                if (nuke === 1'b1 && br_mispred === 1'b1) begin
                    n_both++;
                end
                exp_pc = (nuke === 1'b1) ? nuke_target : br_target;
            end
            prev_stall = (instr_valid === 1'b1) && (decode_ready === 1'b0);
            prev_pc    = instr_pc;
            prev_instr = instr;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * 20);
        $display("watchdog expired before the test sequence finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        seed_draw    = $urandom(32'h4fc2b5dc);
        reset        = 1'b1;
        decode_ready = 1'b0;
        br_mispred   = 1'b0;
        br_target    = '0;
        nuke         = 1'b0;
        nuke_target  = '0;
        host_req     = 1'b0;
        host_we      = 1'b0;
        host_addr    = '0;
        host_wdata   = '0;
        exp_pc       = `FE_RESET_PC;
        prev_stall   = 1'b0;
        run_over     = 1'b0;
        errors       = 0;
        n_xfer       = 0;
        n_reads      = 0;
        n_redirects  = 0;
        n_both       = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        assert (instr_valid === 1'b0 && host_done === 1'b0 && pc_error === 1'b0)
        else begin
            errors++;
            $display("mismatch at %0t: outputs not idle after reset", $time);
        end

        // program load with decode stalled.
        for (int i = 0; i < N_WORDS; i++) begin
            load_word(i, $urandom);
        end
        for (int i = 0; i < N_PRE_READS; i++) begin
            read_and_compare($urandom_range(N_WORDS - 1));
        end

        // flush the word fetched before the load, restart at the reset pc.
        @(posedge clk);
        #1;
        nuke        = 1'b1;
        nuke_target = `FE_RESET_PC;
        @(posedge clk);
        #1;
        nuke = 1'b0;

        fork
            begin
                for (int c = 0; c < N_RUN; c++) begin
                    @(posedge clk);
                    #1;
                    decode_ready = ($urandom_range(99) < 70);
                    br_mispred   = ($urandom_range(15) == 0);
                    nuke         = ($urandom_range(19) == 0);
                    br_target    = random_target();
                    nuke_target  = random_target();
                end
                @(posedge clk);
                #1;
                decode_ready = 1'b0;
                br_mispred   = 1'b0;
                nuke         = 1'b0;
                run_over     = 1'b1;
            end
            begin
                while (!run_over) begin
                    repeat ($urandom_range(6)) @(posedge clk);
                    read_and_compare($urandom_range(N_WORDS - 1));
                end
            end
        join

        repeat (4) @(posedge clk);
        assert (n_xfer > 0) else begin
            errors++;
            $display("no instruction ever reached decode");
        end
        $display("errors %0d, transfers %0d, host reads %0d, redirects %0d (both %0d)",
                 errors, n_xfer, n_reads, n_redirects, n_both);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // free running, first rising edge at half a period.
    always begin
        #(PERIOD_NS / 2.0);
        clk = ~clk;
    end

endmodule

`default_nettype wire

/* rtl/fe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fe_top
    import fe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  logic   decode_ready,
    input  logic   br_mispred,
    input  paddr_t br_target,
    input  logic   nuke,
    input  paddr_t nuke_target,

    output logic   instr_valid,
    output paddr_t instr_pc,
    output instr_t instr,

    input  logic   host_req,
    input  logic   host_we,
    input  paddr_t host_addr,
    input  word_t  host_wdata,
    output logic   host_done,
    output word_t  host_rdata,

    output logic   pc_error
);

    logic   fetch_req;
    paddr_t fetch_addr;
    logic   fetch_gnt;
    logic   fetch_rvalid;
    logic   host_req_m;
    logic   host_we_m;
    paddr_t host_addr_m;
    word_t  host_wdata_m;
    logic   host_gnt;
    logic   host_rvalid;
    logic   mem_en;
    logic   mem_we;
    widx_t  mem_addr;
    word_t  mem_wdata;
    word_t  mem_rdata;

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .reset        (reset),
        .decode_ready (decode_ready),
        .br_mispred   (br_mispred),
        .br_target    (br_target),
        .nuke         (nuke),
        .nuke_target  (nuke_target),
        .instr_valid  (instr_valid),
        .instr_pc     (instr_pc),
        .instr        (instr),
        .req          (fetch_req),
        .addr         (fetch_addr),
        .gnt          (fetch_gnt),
        .rvalid       (fetch_rvalid),
        .mem_rdata    (mem_rdata)
    );

    host_port u_host_port (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_done  (host_done),
        .host_rdata (host_rdata),
        .req_m      (host_req_m),
        .we_m       (host_we_m),
        .addr_m     (host_addr_m),
        .wdata_m    (host_wdata_m),
        .gnt        (host_gnt),
        .rvalid     (host_rvalid),
        .mem_rdata  (mem_rdata)
    );

    mem_arbiter u_mem_arbiter (
        .clk          (clk),
        .reset        (reset),
        .fetch_req    (fetch_req),
        .fetch_addr   (fetch_addr),
        .fetch_gnt    (fetch_gnt),
        .fetch_rvalid (fetch_rvalid),
        .host_req_m   (host_req_m),
        .host_we_m    (host_we_m),
        .host_addr_m  (host_addr_m),
        .host_wdata_m (host_wdata_m),
        .host_gnt     (host_gnt),
        .host_rvalid  (host_rvalid),
        .mem_en       (mem_en),
        .mem_we       (mem_we),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata)
    );

    instr_mem u_instr_mem (
        .clk   (clk),
        .en    (mem_en),
        .we    (mem_we),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

    fetch_chk u_fetch_chk (
        .clk          (clk),
        .reset        (reset),
        .decode_ready (decode_ready),
        .instr_valid  (instr_valid),
        .instr_pc     (instr_pc),
        .br_mispred   (br_mispred),
        .br_target    (br_target),
        .nuke         (nuke),
        .nuke_target  (nuke_target),
        .pc_error     (pc_error)
    );

endmodule

`default_nettype wire

/* rtl/fetch_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_chk
    import fe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  logic   decode_ready,
    input  logic   instr_valid,
    input  paddr_t instr_pc,

    input  logic   br_mispred,
    input  paddr_t br_target,
    input  logic   nuke,
    input  paddr_t nuke_target,

    output logic   pc_error
);

    chk_state_t state;
    paddr_t     exp_pc;
    logic       xfer;
    logic       redirect;
    paddr_t     redirect_pc;

    assign xfer        = instr_valid & decode_ready;
    assign redirect    = nuke | br_mispred;
    assign redirect_pc = nuke ? nuke_target : br_target;

    // nothing to compare against until the first transfer.
    assign pc_error = xfer & (state != idle) & (instr_pc != exp_pc);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= idle;
            exp_pc <= '0;
        end else begin
            if (redirect) begin
                state  <= pdg_branch;
                exp_pc <= redirect_pc;
            end else if (xfer) begin
                state <= pdg_nxt_seq;
                case (state)
                    idle:    exp_pc <= instr_pc + paddr_t'(4);
                    default: exp_pc <= exp_pc + paddr_t'(4);
                endcase
            end
        end
    end

    a_fetch_addr: assert property (@(posedge clk) disable iff (reset)
        (xfer && state != idle) |-> (instr_pc == exp_pc))
        else $error("wrong fetch address (%s), expected %h got %h",
                    state.name(), exp_pc, instr_pc);

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fe_settings.svh"

module fetch_unit
    import fe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  logic   decode_ready,
    input  logic   br_mispred,
    input  paddr_t br_target,
    input  logic   nuke,
    input  paddr_t nuke_target,

    output logic   instr_valid,
    output paddr_t instr_pc,
    output instr_t instr,

    output logic   req,
    output paddr_t addr,
    input  logic   gnt,
    input  logic   rvalid,
    input  word_t  mem_rdata
);

    fetch_state_t state;
    paddr_t       fetch_pc;
    paddr_t       req_pc;
    logic         req_stale;
    logic         rd_busy;
    logic         rd_stale;
    paddr_t       rd_pc;
    logic         buf_valid;
    paddr_t       buf_pc;
    instr_t       buf_instr;
    logic         redirect;
    paddr_t       redirect_pc;
    logic         xfer;
    logic         fill;
    logic         can_issue;

    // nuke wins over a mispredict in the same cycle.
    assign redirect    = nuke | br_mispred;
    assign redirect_pc = nuke ? nuke_target : br_target;

    // the buffered word is wrong path once a redirect shows up.
    assign instr_valid = buf_valid & ~redirect;
    assign instr_pc    = buf_pc;
    assign instr       = buf_instr;
    assign xfer        = instr_valid & decode_ready;

    assign req  = (state == wait_grant);
    assign addr = req_pc;

    // only issue when the buffer is free by the time the word returns.
    assign can_issue = (state == run) & ~rd_busy & (~buf_valid | xfer) & ~redirect;
    assign fill      = rvalid & ~rd_stale & ~redirect;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= run;
            fetch_pc  <= `FE_RESET_PC;
            req_stale <= 1'b0;
            rd_busy   <= 1'b0;
            rd_stale  <= 1'b0;
            buf_valid <= 1'b0;
        end else begin
            case (state)
                run: begin
                    if (can_issue) begin
                        state     <= wait_grant;
                        fetch_pc  <= fetch_pc + paddr_t'(4);
                        req_stale <= 1'b0;
                    end
                end
                wait_grant: begin
                    if (gnt) begin
                        state <= run;
                    end
                    if (redirect) begin
                        req_stale <= 1'b1;
                    end
                end
                default: state <= run;
            endcase

            if (redirect) begin
                fetch_pc <= redirect_pc;
            end

            // tag of the single read in flight.
            if (gnt) begin
                rd_busy  <= 1'b1;
                rd_stale <= req_stale | redirect;
            end else if (rvalid) begin
                rd_busy <= 1'b0;
            end else if (redirect) begin
                rd_stale <= 1'b1;
            end

            if (fill) begin
                buf_valid <= 1'b1;
            end else if (xfer || redirect) begin
                buf_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_issue) begin
            req_pc <= fetch_pc;
        end
        if (gnt) begin
            rd_pc <= req_pc;
        end
        if (fill) begin
            buf_pc    <= rd_pc;
            buf_instr <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

/* rtl/host_port.sv */
`timescale 1ns/1ps
`default_nettype none

module host_port
    import fe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  logic   host_req,
    input  logic   host_we,
    input  paddr_t host_addr,
    input  word_t  host_wdata,
    output logic   host_done,
    output word_t  host_rdata,

    output logic   req_m,
    output logic   we_m,
    output paddr_t addr_m,
    output word_t  wdata_m,
    input  logic   gnt,
    input  logic   rvalid,
    input  word_t  mem_rdata
);

    logic pending;
    logic busy;
    logic wr_done;

    assign req_m      = pending;
    assign host_done  = wr_done | rvalid;
    assign host_rdata = mem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            busy    <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            if (host_req) begin
                pending <= 1'b1;
            end else if (gnt) begin
                pending <= 1'b0;
            end
            wr_done <= pending & gnt & we_m;
            // open from the strobe to its completion.
            if (host_req) begin
                busy <= 1'b1;
            end else if (host_done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (host_req) begin
            we_m    <= host_we;
            addr_m  <= host_addr;
            wdata_m <= host_wdata;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        host_req |-> !busy)
        else $error("host request while another is outstanding");

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fe_settings.svh"

module mem_arbiter
    import fe_pkg::*;
(
    input  logic   clk,
    input  logic   reset,

    input  logic   fetch_req,
    input  paddr_t fetch_addr,
    output logic   fetch_gnt,
    output logic   fetch_rvalid,

    input  logic   host_req_m,
    input  logic   host_we_m,
    input  paddr_t host_addr_m,
    input  word_t  host_wdata_m,
    output logic   host_gnt,
    output logic   host_rvalid,

    output logic   mem_en,
    output logic   mem_we,
    output widx_t  mem_addr,
    output word_t  mem_wdata
);

    // set when host won the last granted cycle.
    logic last_host;

    assign fetch_gnt = fetch_req & (~host_req_m | last_host);
    assign host_gnt  = host_req_m & (~fetch_req | ~last_host);

    assign mem_en    = fetch_gnt | host_gnt;
    assign mem_we    = host_gnt & host_we_m;
    assign mem_addr  = host_gnt ? host_addr_m[`FE_ADDR_W-1:2] : fetch_addr[`FE_ADDR_W-1:2];
    assign mem_wdata = host_wdata_m;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_host    <= 1'b0;
            fetch_rvalid <= 1'b0;
            host_rvalid  <= 1'b0;
        end else begin
            if (mem_en) begin
                last_host <= host_gnt;
            end
            // owner of the read now in the memory pipe.
            fetch_rvalid <= fetch_gnt;
            host_rvalid  <= host_gnt & ~host_we_m;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (reset)
        !(fetch_gnt && host_gnt))
        else $error("both peers granted at once");

endmodule

`default_nettype wire

/* rtl/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fe_settings.svh"

module instr_mem
    import fe_pkg::*;
(
    input  logic  clk,
    input  logic  en,
    input  logic  we,
    input  widx_t addr,
    input  word_t wdata,
    output word_t rdata
);

    word_t mem [0:`FE_MEM_WORDS-1];

    // read-first, a write returns the old word.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/fe_pkg.sv */
`default_nettype none

`include "fe_settings.svh"

package fe_pkg;

    typedef logic [`FE_ADDR_W-1:0] paddr_t;
    typedef logic [31:0]           word_t;
    typedef logic [31:0]           instr_t;
    typedef logic [`FE_ADDR_W-3:0] widx_t;

    // fetch checker view of the instruction stream.
    typedef enum logic [1:0] {
        idle,
        pdg_nxt_seq,
        pdg_branch
    } chk_state_t;

    // fetch request side.
    typedef enum logic {
        run,
        wait_grant
    } fetch_state_t;

endpackage

`default_nettype wire

/* rtl/fe_settings.svh */
`ifndef FE_SETTINGS_SVH
`define FE_SETTINGS_SVH

// byte address width of the front end.
`define FE_ADDR_W 12

// depth of the shared word memory.
`define FE_MEM_WORDS 1024

// first fetch address after reset.
`define FE_RESET_PC 12'h000

`endif
